//--- dv/tb_board_top.sv
// Board testbench: clock, reset, key stimulus, counter and VGA checks, watchdog, report
module tb_board_top
    import board_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    // About 30 step ticks of tests, overlapped by one VGA frame, plus margin
    localparam int watchdog_cycles = 30 * 1024 + 800 * 525 + 20_000;

    logic   clk;
    logic   rst_n;
    key_t   key_raw;
    logic   sio_clk;
    logic   sio_stb;
    logic   sio_data;
    logic   hsync;
    logic   vsync;
    logic   display_on;
    rgb_t   pixel;
    x_t     x;
    y_t     y;

    logic   frame_valid;
    count_t frame_count;
    led_t   frame_led;
    int     mon_errors;

    int     error_count;
    int     errors_at_start;
    int     tests_run;
    int     tests_failed;
    int     exp_step;         // Expected count change from one frame to the next
    count_t last_count;
    int     cyc;              // Cycles since reset release
    int     hs_low_len;
    int     hs_period;
    logic   hs_seen;
    int     de_len;
    int     vs_low_len;
    int     vs_rises;

    board_specific_top board_specific_top_inst (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .key_raw    ( key_raw    ),
        .sio_clk    ( sio_clk    ),
        .sio_stb    ( sio_stb    ),
        .sio_data   ( sio_data   ),
        .hsync      ( hsync      ),
        .vsync      ( vsync      ),
        .display_on ( display_on ),
        .pixel      ( pixel      ),
        .x          ( x          ),
        .y          ( y          )
    );

    tm1638_monitor bus_monitor (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .sio_clk     ( sio_clk     ),
        .sio_stb     ( sio_stb     ),
        .sio_data    ( sio_data    ),
        .frame_valid ( frame_valid ),
        .frame_count ( frame_count ),
        .frame_led   ( frame_led   ),
        .error_count ( mon_errors  )
    );

    always #5ns clk = !clk;

    //------------------------------------------------------------------------
    // Reference counters

    always @(posedge clk)
    begin
        if (!rst_n)
        begin
            cyc        <= 0;
            hs_low_len <= 0;
            hs_period  <= 0;
            hs_seen    <= 1'b0;
            de_len     <= 0;
            vs_low_len <= 0;
            vs_rises   <= 0;
            last_count <= '0;
        end
        else
        begin
            cyc        <= cyc + 1;
            hs_low_len <= hsync ? 0 : hs_low_len + 1;
            de_len     <= display_on ? de_len + 1 : 0;
            vs_low_len <= vsync ? 0 : vs_low_len + 1;

            if (!hsync && hs_low_len == 0)       // hsync falls
            begin
                hs_period <= 1;
                hs_seen   <= 1'b1;
            end
            else
                hs_period <= hs_period + 1;

            if (vsync && vs_low_len != 0)
                vs_rises <= vs_rises + 1;
            if (frame_valid)
                last_count <= frame_count;
        end
    end

    //------------------------------------------------------------------------
    // Helpers

    task automatic show_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        error_count++;
        $display("ERROR %0t: %s got %0h expected %0h", $time, name, got, exp);
    endtask

    task automatic report_failure(input string what);
        error_count++;
        $display("At %0t: %s", $time, what);
    endtask

    task automatic wait_frame();
        int waited;

        waited = 0;
        do
        begin
            @(posedge clk);
            waited++;
        end
        while (!frame_valid && waited < 2 * tick_period_cycles);

        if (!frame_valid)
            report_failure("no TM1638 frame arrived within two tick periods");
    endtask

    task automatic run_glitches(input int count);
        int width;
        int gap;
        int k;

        for (int i = 0; i < count; i++)
        begin
            width = $urandom_range(debounce_cycles - 1, 1);
            gap   = $urandom_range(debounce_cycles - 1, 1);
            k     = $urandom_range(1, 0);    // Pause or direction key
            @(posedge clk);
            key_raw[k] <= 1'b1;
            repeat (width) @(posedge clk);
            key_raw[k] <= 1'b0;
            repeat (gap) @(posedge clk);
        end
    endtask

    task automatic reverse_direction();
        wait_frame();
        key_raw[1] <= 1'b1;
        exp_step   <= -exp_step;
        repeat (2 * debounce_cycles) @(posedge clk);
        key_raw[1] <= 1'b0;
    endtask

    task automatic finish_test(input string name);
        int total;

        total = error_count + mon_errors;
        tests_run++;
        if (total == errors_at_start)
            $display("Test %-24s ok", name);
        else
        begin
            tests_failed++;
            $display("Test %-24s FAILED with %0d errors", name, total - errors_at_start);
        end
        errors_at_start = total;
    endtask

    //------------------------------------------------------------------------
    // Checks

    a_reset_values: assert property (@(posedge clk)
        $rose(rst_n) |-> sio_stb && sio_clk && sio_data && hsync && vsync)
        else report_failure("outputs were not idle right after reset");

    a_idle_before_tick: assert property (@(posedge clk) disable iff (!rst_n)
        cyc < 1024 |-> sio_stb && sio_clk)
        else report_failure("TM1638 bus became active before the first step tick");

    a_count_step: assert property (@(posedge clk) disable iff (!rst_n)
        frame_valid |-> frame_count == count_t'(last_count + exp_step))
        else show_mismatch("frame_count", $sampled(frame_count),
                           count_t'($sampled(last_count) + $sampled(exp_step)));

    a_led_value: assert property (@(posedge clk) disable iff (!rst_n)
        frame_valid |-> frame_led == 8'(last_count + exp_step))
        else show_mismatch("frame_led", $sampled(frame_led),
                           8'($sampled(last_count) + $sampled(exp_step)));

    a_hsync_width: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(hsync) |-> hs_low_len == 96)
        else show_mismatch("hsync low cycles", $sampled(hs_low_len), 96);

    a_hsync_period: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(hsync) && hs_seen |-> hs_period == 800)
        else show_mismatch("hsync period", $sampled(hs_period), 800);

    a_line_visible: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(display_on) |-> de_len == 640)
        else show_mismatch("display_on cycles", $sampled(de_len), 640);

    a_vsync_width: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(vsync) |-> vs_low_len == 2 * 800)
        else show_mismatch("vsync low cycles", $sampled(vs_low_len), 2 * 800);

    // Pulse starts after 490 lines of a 525 line frame
    a_vsync_start: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(vsync) |-> cyc % (525 * 800) == 490 * 800)
        else show_mismatch("vsync start cycle", $sampled(cyc), 490 * 800);

    a_pixel_blank: assert property (@(posedge clk) disable iff (!rst_n)
        !display_on |-> pixel == '0)
        else show_mismatch("pixel", $sampled(pixel), 0);

    a_pixel_red: assert property (@(posedge clk) disable iff (!rst_n)
        display_on |-> pixel.red == x[7:0])
        else show_mismatch("pixel.red", $sampled(pixel.red), $sampled(x[7:0]));

    a_pixel_green: assert property (@(posedge clk) disable iff (!rst_n)
        display_on |-> pixel.green == y[7:0])
        else show_mismatch("pixel.green", $sampled(pixel.green), $sampled(y[7:0]));

    // Count holds from its step until the frame showing it is out
    a_pixel_blue: assert property (@(posedge clk) disable iff (!rst_n)
        frame_valid |-> pixel.blue == (display_on ? 8'(last_count + exp_step) : 8'h00))
        else show_mismatch("pixel.blue", $sampled(pixel.blue),
                           $sampled(display_on) ? 8'($sampled(last_count) + $sampled(exp_step))
                                                : 8'h00);

    //------------------------------------------------------------------------
    // Stimulus

    initial
    begin
        void'($urandom(77025));
        clk      = 1'b0;
        rst_n    = 1'b0;
        key_raw  = '0;
        exp_step = 1;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        wait_frame();                            // Count 1 expected
        finish_test("reset_and_first_frame");

        repeat (3) wait_frame();
        finish_test("count_up");

        wait_frame();
        key_raw[0] <= 1'b1;                      // Hold pause
        exp_step   <= 0;
        repeat (3) wait_frame();
        key_raw[0] <= 1'b0;
        exp_step   <= 1;
        repeat (2) wait_frame();
        run_glitches(60);
        wait_frame();
        finish_test("pause_and_glitches");

        reverse_direction();
        repeat (3) wait_frame();
        reverse_direction();                     // Back to counting up
        repeat (3) wait_frame();
        finish_test("reversal");

        while (vs_rises == 0 && cyc < 525 * 800 + 1000)
            @(posedge clk);
        if (vs_rises == 0)
            report_failure("vsync never completed a pulse within one VGA frame");
        finish_test("vga_timing");

        $display("Tests run %0d, failed %0d, errors %0d",
                 tests_run, tests_failed, error_count + mon_errors);
        if (error_count + mon_errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

    initial
    begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the tests did not finish",
                 watchdog_cycles);
        $display("Testbench failed");
        $finish;
    end

endmodule

//--- dv/tm1638_monitor.sv
// TM1638 bus monitor: byte and frame decoder with frame format assertions
module tm1638_monitor
    import board_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   sio_clk,
    input  logic   sio_stb,
    input  logic   sio_data,
    output logic   frame_valid,
    output count_t frame_count,
    output led_t   frame_led,
    output int     error_count
);

    timeunit 1ns;
    timeprecision 100ps;

    // Digit codes as they appear on the wire, segment a in bit 0
    localparam logic [7:0] wire_seg [16] = '{
        8'h3F, 8'h06, 8'h5B, 8'h4F, 8'h66, 8'h6D, 8'h7D, 8'h07,
        8'h7F, 8'h6F, 8'h77, 8'h7C, 8'h39, 8'h5E, 8'h79, 8'h71
    };

    logic       sclk_q;
    logic       stb_q;
    logic       stb_rise;
    logic [7:0] shift;
    logic [2:0] bit_cnt;
    int         n_bytes;
    logic [1:0] xfer_num;
    logic [7:0] xfer_bytes [17];
    logic [7:0] data_bytes [16];   // Indexed by TM1638 address
    logic [7:0] mode_byte;
    logic [7:0] addr_byte;
    logic [7:0] ctrl_byte;
    int         mode_len;
    int         data_len;
    int         ctrl_len;
    logic       digits_ok;
    logic       blank_ok;
    logic       led_bytes_ok;

    task automatic value_wrong(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        error_count++;
        $display("ERROR %0t: %s got %0h expected %0h", $time, name, got, exp);
    endtask

    task automatic format_wrong(input string what);
        error_count++;
        $display("At %0t the TM1638 frame was malformed: %s", $time, what);
    endtask

    // Upper bit flags a known code, low nibble is the digit value
    function automatic logic [4:0] decode_digit(input logic [7:0] b);
        logic [4:0] result;

        result = '0;
        for (int n = 0; n < 16; n++)
            if (wire_seg[n] == b)
                result = {1'b1, 4'(n)};
        return result;
    endfunction

    //------------------------------------------------------------------------
    // Bit and byte collection

    assign stb_rise = sio_stb && !stb_q;

    always @(posedge clk)
    begin
        if (!rst_n)
        begin
            sclk_q      <= 1'b1;
            stb_q       <= 1'b1;
            bit_cnt     <= '0;
            n_bytes     <= 0;
            xfer_num    <= '0;
            frame_valid <= 1'b0;
        end
        else
        begin
            sclk_q      <= sio_clk;
            stb_q       <= sio_stb;
            frame_valid <= 1'b0;

            if (sio_clk && !sclk_q && !sio_stb)
            begin
                shift   <= {sio_data, shift[7:1]};   // LSB first
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == 3'd7)
                begin
                    if (n_bytes < 17)
                        xfer_bytes[n_bytes] <= {sio_data, shift[7:1]};
                    n_bytes <= n_bytes + 1;
                end
            end

            if (stb_rise)                            // End of one transfer
            begin
                n_bytes  <= 0;
                bit_cnt  <= '0;
                xfer_num <= (xfer_num == 2'd2) ? 2'd0 : xfer_num + 1'b1;
                case (xfer_num)
                    2'd0:
                    begin
                        mode_byte <= xfer_bytes[0];
                        mode_len  <= n_bytes;
                    end
                    2'd1:
                    begin
                        addr_byte <= xfer_bytes[0];
                        data_len  <= n_bytes;
                        for (int a = 0; a < 16; a++)
                            data_bytes[a] <= xfer_bytes[a + 1];
                    end
                    default:
                    begin
                        ctrl_byte   <= xfer_bytes[0];
                        ctrl_len    <= n_bytes;
                        frame_valid <= 1'b1;
                    end
                endcase
            end
        end
    end

    //------------------------------------------------------------------------
    // Frame decode

    always_comb
    begin
        logic [4:0] digit;

        frame_count  = '0;
        frame_led    = '0;
        digits_ok    = 1'b1;
        blank_ok     = 1'b1;
        led_bytes_ok = 1'b1;

        for (int k = 0; k < 4; k++)
        begin
            digit     = decode_digit(data_bytes[2 * k]);
            digits_ok = digits_ok && digit[4];
            frame_count[4 * (3 - k) +: 4] = digit[3:0];   // Leftmost digit is the top nibble
        end

        for (int k = 4; k < 8; k++)
            blank_ok = blank_ok && (data_bytes[2 * k] == 8'h00);

        for (int k = 0; k < 8; k++)
        begin
            led_bytes_ok = led_bytes_ok && (data_bytes[2 * k + 1][7:1] == 7'b0);
            frame_led[k] = data_bytes[2 * k + 1][0];
        end
    end

    //------------------------------------------------------------------------

    a_mode_byte: assert property (@(posedge clk) disable iff (!rst_n)
        frame_valid |-> mode_byte == 8'h40)
        else value_wrong("mode_byte", $sampled(mode_byte), 8'h40);

    a_addr_byte: assert property (@(posedge clk) disable iff (!rst_n)
        frame_valid |-> addr_byte == 8'hC0)
        else value_wrong("addr_byte", $sampled(addr_byte), 8'hC0);

    a_ctrl_byte: assert property (@(posedge clk) disable iff (!rst_n)
        frame_valid |-> ctrl_byte == 8'h8F)
        else value_wrong("ctrl_byte", $sampled(ctrl_byte), 8'h8F);

    a_data_len: assert property (@(posedge clk) disable iff (!rst_n)
        frame_valid |-> data_len == 17)
        else value_wrong("data_len", $sampled(data_len), 17);

    a_cmd_len: assert property (@(posedge clk) disable iff (!rst_n)
        frame_valid |-> mode_len == 1 && ctrl_len == 1)
        else format_wrong("a command transfer did not hold exactly one byte");

    a_whole_bytes: assert property (@(posedge clk) disable iff (!rst_n)
        stb_rise |-> bit_cnt == 3'd0)
        else format_wrong("strobe rose in the middle of a byte");

    a_digit_codes: assert property (@(posedge clk) disable iff (!rst_n)
        frame_valid |-> digits_ok)
        else format_wrong("a count digit is not a seven-segment hex code");

    a_blank_digits: assert property (@(posedge clk) disable iff (!rst_n)
        frame_valid |-> blank_ok)
        else format_wrong("digits 4 to 7 are not blank");

    a_led_bytes: assert property (@(posedge clk) disable iff (!rst_n)
        frame_valid |-> led_bytes_ok)
        else format_wrong("an LED byte is neither 0x00 nor 0x01");

    a_led_match: assert property (@(posedge clk) disable iff (!rst_n)
        frame_valid |-> frame_led == frame_count[7:0])
        else value_wrong("frame_led", $sampled(frame_led), $sampled(frame_count[7:0]));

endmodule

//--- rtl/board_pkg.sv
// Board timing constants, TM1638 command bytes, vector typedefs, panel and pixel structs
package board_pkg;

    //------------------------------------------------------------------------
    // Clock and slow timing

    localparam int clk_mhz            = 12;
    localparam int tick_period_cycles = 1024;   // Shortened counter step period
    localparam int debounce_cycles    = 16;
    localparam int sio_half_period    = 2;      // clk cycles per sio_clk phase

    //------------------------------------------------------------------------
    // 640x480 VGA timing

    localparam int h_visible = 640;
    localparam int h_front   = 16;
    localparam int h_sync    = 96;
    localparam int h_back    = 48;
    localparam int h_total   = h_visible + h_front + h_sync + h_back;  // 800

    localparam int v_visible = 480;
    localparam int v_front   = 10;
    localparam int v_sync    = 2;
    localparam int v_back    = 33;
    localparam int v_total   = v_visible + v_front + v_sync + v_back;  // 525

    localparam int w_x    = 10;
    localparam int w_y    = 10;
    localparam int n_keys = 3;

    // TM1638 commands
    localparam logic [7:0] tm_cmd_write_auto = 8'h40;  // Write, auto increment
    localparam logic [7:0] tm_cmd_addr_0     = 8'hC0;  // Start at address 0
    localparam logic [7:0] tm_cmd_display_on = 8'h8F;  // Display on, max brightness

    //------------------------------------------------------------------------
    // Types

    typedef logic [w_x    - 1:0] x_t;
    typedef logic [w_y    - 1:0] y_t;
    typedef logic [         7:0] color_t;
    typedef logic [         7:0] seg_t;    // abcdefgh, dot in bit 0
    typedef logic [        15:0] count_t;
    typedef logic [         7:0] led_t;
    typedef logic [n_keys - 1:0] key_t;    // 0 pause, 1 direction, 2 spare

    typedef struct packed {
        seg_t [0:7] digit;                 // Digit 0 is the leftmost
        led_t       led;
    } panel_t;

    typedef struct packed {
        color_t red;
        color_t green;
        color_t blue;
    } rgb_t;

endpackage

//--- rtl/board_specific_top.sv
// Board top level wiring keys, tick, lab design, TM1638 controller and VGA timing
module board_specific_top
    import board_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  key_t key_raw,
    output logic sio_clk,
    output logic sio_stb,
    output logic sio_data,
    output logic hsync,
    output logic vsync,
    output logic display_on,
    output rgb_t pixel,
    output x_t   x,
    output y_t   y
);

    key_t   key_level;
    key_t   key_press;
    logic   step_tick;
    panel_t panel;
    logic   panel_update;

    //------------------------------------------------------------------------
    // Input side

    key_debounce i_key_debounce (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .key_raw   ( key_raw   ),
        .key_level ( key_level ),
        .key_press ( key_press )
    );

    slow_tick_gen i_slow_tick_gen (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .step_tick ( step_tick )
    );

    //------------------------------------------------------------------------

    lab_top i_lab_top (
        .clk          ( clk          ),
        .rst_n        ( rst_n        ),
        .key_level    ( key_level    ),
        .key_press    ( key_press    ),
        .step_tick    ( step_tick    ),
        .x            ( x            ),
        .y            ( y            ),
        .display_on   ( display_on   ),
        .panel        ( panel        ),
        .panel_update ( panel_update ),
        .pixel        ( pixel        )
    );

    //------------------------------------------------------------------------
    // Output side

    tm1638_board_controller i_tm1638 (
        .clk          ( clk          ),
        .rst_n        ( rst_n        ),
        .panel        ( panel        ),
        .panel_update ( panel_update ),
        .sio_clk      ( sio_clk      ),
        .sio_stb      ( sio_stb      ),
        .sio_data     ( sio_data     )
    );

    vga_timing i_vga (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .x          ( x          ),
        .y          ( y          ),
        .display_on ( display_on ),
        .hsync      ( hsync      ),
        .vsync      ( vsync      )
    );

endmodule

//--- rtl/key_debounce.sv
// Key synchronizer and per-key debouncer with clean levels and press pulses
module key_debounce
    import board_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  key_t key_raw,
    output key_t key_level,
    output key_t key_press
);

    key_t sync_1;
    key_t sync_2;

    logic [$clog2(debounce_cycles) - 1:0] stable_cnt [n_keys];

    //------------------------------------------------------------------------

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            sync_1    <= '0;
            sync_2    <= '0;
            key_level <= '0;
            key_press <= '0;

            for (int i = 0; i < n_keys; i++)
                stable_cnt[i] <= '0;
        end
        else
        begin
            sync_1    <= key_raw;                // Metastability guard
            sync_2    <= sync_1;
            key_press <= '0;

            for (int i = 0; i < n_keys; i++)
            begin
                if (sync_2[i] == key_level[i])
                    stable_cnt[i] <= '0;         // Glitch gone, start over
                else if (stable_cnt[i] == ($bits(stable_cnt[i]))'(debounce_cycles - 1))
                begin
                    stable_cnt[i] <= '0;
                    key_level[i]  <= sync_2[i];
                    key_press[i]  <= sync_2[i];  // Only on an accepted rise
                end
                else
                    stable_cnt[i] <= stable_cnt[i] + 1'b1;
            end
        end
    end

endmodule

//--- rtl/lab_top.sv
// Lab design: up/down counter, seven-segment panel and VGA test picture
module lab_top
    import board_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  key_t   key_level,
    input  key_t   key_press,
    input  logic   step_tick,
    input  x_t     x,
    input  y_t     y,
    input  logic   display_on,
    output panel_t panel,
    output logic   panel_update,
    output rgb_t   pixel
);

    count_t count;
    logic   count_down;

    //------------------------------------------------------------------------
    // Counter

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            count        <= '0;
            count_down   <= 1'b0;
            panel_update <= 1'b0;
        end
        else
        begin
            panel_update <= step_tick;           // Also when paused

            if (key_press[1])
                count_down <= !count_down;

            if (step_tick && !key_level[0])
                count <= count_down ? count - 1'b1 : count + 1'b1;
        end
    end

    //------------------------------------------------------------------------
    // Panel

    function automatic seg_t hex_to_seg(input logic [3:0] nibble);
        seg_t seg;

        case (nibble)
            4'h0: seg = 8'b1111_1100;
            4'h1: seg = 8'b0110_0000;
            4'h2: seg = 8'b1101_1010;
            4'h3: seg = 8'b1111_0010;
            4'h4: seg = 8'b0110_0110;
            4'h5: seg = 8'b1011_0110;
            4'h6: seg = 8'b1011_1110;
            4'h7: seg = 8'b1110_0000;
            4'h8: seg = 8'b1111_1110;
            4'h9: seg = 8'b1111_0110;
            4'hA: seg = 8'b1110_1110;
            4'hB: seg = 8'b0011_1110;
            4'hC: seg = 8'b1001_1100;
            4'hD: seg = 8'b0111_1010;
            4'hE: seg = 8'b1001_1110;
            default: seg = 8'b1000_1110;         // F
        endcase

        return seg;
    endfunction

    always_comb
    begin
        panel = '0;                              // Digits 4..7 blank

        for (int i = 0; i < 4; i++)
            panel.digit[i] = hex_to_seg(count[4 * (3 - i) +: 4]);  // MSB nibble left

        panel.led = count[7:0];
    end

    //------------------------------------------------------------------------
    // Test picture

    always_comb
    begin
        pixel = '0;

        if (display_on)
        begin
            pixel.red   = x[7:0];
            pixel.green = y[7:0];
            pixel.blue  = count[7:0];
        end
    end

endmodule

//--- rtl/slow_tick_gen.sv
// Wrapping cycle counter producing a one-cycle step tick
module slow_tick_gen
    import board_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    output logic step_tick
);

    logic [$clog2(tick_period_cycles) - 1:0] cycle_cnt;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            cycle_cnt <= '0;
            step_tick <= 1'b0;
        end
        else
        begin
            step_tick <= (cycle_cnt == ($bits(cycle_cnt))'(tick_period_cycles - 1));

            if (cycle_cnt == ($bits(cycle_cnt))'(tick_period_cycles - 1))
                cycle_cnt <= '0;
            else
                cycle_cnt <= cycle_cnt + 1'b1;
        end
    end

endmodule

//--- rtl/tm1638_board_controller.sv
// Write-only TM1638 controller FSM serializing the panel into command and data bytes
module tm1638_board_controller
    import board_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  panel_t panel,
    input  logic   panel_update,
    output logic   sio_clk,
    output logic   sio_stb,
    output logic   sio_data
);

    typedef enum logic [2:0] {
        IDLE,
        START,
        SHIFT,
        STROBE_GAP,
        DONE
    } state_t;

    typedef logic [$clog2(2 * sio_half_period) - 1:0] div_t;

    state_t     state;
    panel_t     frame;
    logic [1:0] xfer;       // 0 mode command, 1 address and data, 2 display control
    logic [4:0] byte_idx;   // Byte within the transfer
    logic [2:0] bit_cnt;
    div_t       div;
    logic [7:0] shift_reg;
    logic       last_byte;

    //------------------------------------------------------------------------

    function automatic logic [7:0] reverse_bits(input seg_t seg);
        logic [7:0] result;

        for (int i = 0; i < 8; i++)
            result[i] = seg[7 - i];

        return result;
    endfunction

    function automatic logic [7:0] frame_byte(
        input logic [1:0] xfer_i,
        input logic [4:0] idx_i,
        input panel_t     p
    );
        logic [3:0] addr;
        logic [7:0] result;

        addr = 4'(idx_i - 5'd1);

        case (xfer_i)
            2'd0: result = tm_cmd_write_auto;
            2'd1:
                if (idx_i == 5'd0)
                    result = tm_cmd_addr_0;
                else if (!addr[0])
                    result = reverse_bits(p.digit[addr[3:1]]);  // Segment a first
                else
                    result = {7'b0, p.led[addr[3:1]]};          // LED for this position
            default: result = tm_cmd_display_on;
        endcase

        return result;
    endfunction

    assign last_byte = (xfer != 2'd1) || (byte_idx == 5'd16);

    //------------------------------------------------------------------------

    always_ff @(posedge clk)
    begin
        if (state == IDLE && panel_update)
            frame <= panel;
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state     <= IDLE;
            xfer      <= '0;
            byte_idx  <= '0;
            bit_cnt   <= '0;
            div       <= '0;
            shift_reg <= '0;
            sio_clk   <= 1'b1;
            sio_stb   <= 1'b1;
            sio_data  <= 1'b1;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    if (panel_update)
                    begin
                        xfer  <= 2'd0;
                        state <= START;
                    end
                end

                START:
                begin
                    sio_stb   <= 1'b0;
                    div       <= '0;
                    bit_cnt   <= '0;
                    byte_idx  <= '0;
                    shift_reg <= frame_byte(xfer, 5'd0, frame);
                    state     <= SHIFT;
                end

                SHIFT:
                begin
                    if (div != div_t'(sio_half_period - 1))
                        div <= div + 1'b1;
                    else
                    begin
                        div <= '0;

                        if (sio_clk)
                        begin
                            sio_clk   <= 1'b0;        // Data moves while clock low
                            sio_data  <= shift_reg[0];
                            shift_reg <= shift_reg >> 1;
                        end
                        else
                        begin
                            sio_clk <= 1'b1;          // TM1638 samples here
                            bit_cnt <= bit_cnt + 1'b1;

                            if (bit_cnt == 3'd7)
                            begin
                                if (last_byte)
                                    state <= STROBE_GAP;
                                else
                                begin
                                    byte_idx  <= byte_idx + 1'b1;
                                    shift_reg <= frame_byte(xfer, byte_idx + 5'd1, frame);
                                end
                            end
                        end
                    end
                end

                STROBE_GAP:
                begin
                    div <= div + 1'b1;

                    // Hold strobe low for half a period, then high for another
                    if (div == div_t'(sio_half_period - 1))
                    begin
                        sio_stb  <= 1'b1;
                        sio_data <= 1'b1;
                    end

                    if (div == div_t'(2 * sio_half_period - 1))
                    begin
                        div <= '0;

                        if (xfer == 2'd2)
                            state <= DONE;
                        else
                        begin
                            xfer  <= xfer + 1'b1;
                            state <= START;
                        end
                    end
                end

                default:
                    state <= IDLE;                    // DONE
            endcase
        end
    end

    //------------------------------------------------------------------------

    a_clk_inside_strobe: assert property (
        @(posedge clk) disable iff (!rst_n)
        !$stable(sio_clk) |-> !sio_stb
    );

    // Lab updates come every tick period and a frame must finish before that
    a_update_when_idle: assert property (
        @(posedge clk) disable iff (!rst_n)
        panel_update |-> state == IDLE
    );

endmodule

//--- rtl/vga_timing.sv
// VGA 640x480 timing generator with syncs, display enable and pixel coordinates
module vga_timing
    import board_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    output x_t   x,
    output y_t   y,
    output logic display_on,
    output logic hsync,
    output logic vsync
);

    x_t h_cnt;
    y_t v_cnt;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            h_cnt <= '0;
            v_cnt <= '0;
        end
        else if (h_cnt == x_t'(h_total - 1))
        begin
            h_cnt <= '0;

            if (v_cnt == y_t'(v_total - 1))
                v_cnt <= '0;
            else
                v_cnt <= v_cnt + 1'b1;
        end
        else
            h_cnt <= h_cnt + 1'b1;
    end

    //------------------------------------------------------------------------
    // Everything below decodes the same two counters

    assign x = h_cnt;
    assign y = v_cnt;

    assign display_on = (h_cnt < x_t'(h_visible)) && (v_cnt < y_t'(v_visible));

    // Active low pulses after the front porch
    assign hsync = !((h_cnt >= x_t'(h_visible + h_front))
                  && (h_cnt <  x_t'(h_visible + h_front + h_sync)));

    assign vsync = !((v_cnt >= y_t'(v_visible + v_front))
                  && (v_cnt <  y_t'(v_visible + v_front + v_sync)));

    //------------------------------------------------------------------------

    // Both counters wrap at the line and frame totals
    a_counter_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        (h_cnt < x_t'(h_total)) && (v_cnt < y_t'(v_total))
    );

endmodule

//--- tb.f
rtl/board_pkg.sv
rtl/key_debounce.sv
rtl/slow_tick_gen.sv
rtl/lab_top.sv
rtl/tm1638_board_controller.sv
rtl/vga_timing.sv
rtl/board_specific_top.sv
dv/tm1638_monitor.sv
dv/tb_board_top.sv
